// ==== compile.f ====
+incdir+src
+incdir+bench
src/rv_pkg.sv
src/decode.sv
src/reg_file.sv
src/execute.sv
src/result.sv
src/rv_core.sv
bench/rv_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f compile.f --top-module rv_core_tb -o rv_core_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/rv_core_tb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -q -F '*** TEST PASSED ***'; then
  exit 0
fi
exit 1

// ==== bench/rv_model.svh ====
`ifndef RV_MODEL_SVH
`define RV_MODEL_SVH

// architectural state of the reference model
typedef struct packed {
  logic [31:0][31:0] regs;
  rv_pkg::word_t     pc;
} modelState_t;

// what the core should report one cycle after the strobe
typedef struct packed {
  logic            wbValid;
  rv_pkg::regIdx_t rd;
  rv_pkg::word_t   data;
  rv_pkg::word_t   pc;
} expect_t;

typedef struct packed {
  modelState_t next;
  expect_t     exp;
} stepResult_t;

function automatic rv_pkg::word_t aluRef(input logic [2:0] f3, input logic subSel,
                                         input logic sraSel, input rv_pkg::word_t a,
                                         input rv_pkg::word_t b);
  case (f3)
    3'b000: return subSel ? a - b : a + b;
    3'b001: return a << b[4:0];
    3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011: return (a < b) ? 32'd1 : 32'd0;
    3'b100: return a ^ b;
    3'b101: begin
      if (sraSel) return $signed(a) >>> b[4:0];
      return a >> b[4:0];
    end
    3'b110: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic takeRef(input logic [2:0] f3, input rv_pkg::word_t a,
                                 input rv_pkg::word_t b);
  case (f3)
    3'b000: return a == b;
    3'b001: return a != b;
    3'b100: return $signed(a) < $signed(b);
    3'b101: return $signed(a) >= $signed(b);
    3'b110: return a < b;
    3'b111: return a >= b;
    default: return 1'b0;
  endcase
endfunction

// one instruction applied to the model state
function automatic stepResult_t modelStep(input modelState_t st, input rv_pkg::word_t w);
  modelState_t     s;
  stepResult_t     r;
  rv_pkg::regIdx_t rd;
  rv_pkg::word_t   a;
  rv_pkg::word_t   b;
  rv_pkg::word_t   immI;
  rv_pkg::word_t   value;
  rv_pkg::word_t   nextPc;
  logic            writes;
  s = st;
  rd = w[11:7];
  a = s.regs[w[19:15]];
  b = s.regs[w[24:20]];
  immI = {{20{w[31]}}, w[31:20]};
  nextPc = s.pc + 32'd4;
  value = nextPc;
  writes = 1'b1;
  case (w[6:0])
    `OP_LUI: value = {w[31:12], 12'd0};
    `OP_JAL: nextPc = s.pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    `OP_JALR: nextPc = (a + immI) & 32'hffff_fffe;
    `OP_BRANCH: begin
      writes = 1'b0;
      if (takeRef(w[14:12], a, b)) nextPc = s.pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    end
    `OP_OPIMM: value = aluRef(w[14:12], 1'b0, w[30], a, immI);
    `OP_OP: value = aluRef(w[14:12], w[30], w[30], a, b);
    default: writes = 1'b0;
  endcase
  if (rd == 5'd0) writes = 1'b0;
  if (writes) s.regs[rd] = value;
  s.pc = nextPc;
  r.next = s;
  r.exp.wbValid = writes;
  r.exp.rd = rd;
  r.exp.data = value;
  r.exp.pc = nextPc;
  return r;
endfunction

`endif

// ==== bench/rv_core_tb.sv ====
`default_nettype none

`include "rv_defines.svh"

module rv_core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  `include "rv_model.svh"

  localparam int ALU_ROUNDS = 4;
  localparam int STREAM_LEN = 300;
  // alu with setup and x0, branch, jump, no-op, stream
  localparam int TOTAL_INSTRS = 14 + 19 * ALU_ROUNDS + 3 + 39 + 8 + 12 + STREAM_LEN;
  localparam int CYCLE_LIMIT = 2 * TOTAL_INSTRS + 100;

  logic            clk = 1'b0;
  logic            arstN;
  rv_pkg::word_t   instr;
  logic            instrValid;
  rv_pkg::word_t   pc;
  logic            wbValid;
  rv_pkg::regIdx_t wbRd;
  rv_pkg::word_t   wbData;

  integer        seed;
  int            errorCount;
  int            checkCount;
  int            testNum;
  int            testErrors;
  int            failedTests;
  logic          running;
  logic          armed;
  rv_pkg::word_t lastPc;
  modelState_t   model;
  expect_t       expQ[$];

  rv_core u_dut (
    .clk        (clk),
    .arstN      (arstN),
    .instr      (instr),
    .instrValid (instrValid),
    .pc         (pc),
    .wbValid    (wbValid),
    .wbRd       (wbRd),
    .wbData     (wbData)
  );

  always #4 clk = ~clk;

  function automatic rv_pkg::word_t rnd();
    return $random(seed);
  endfunction

  function automatic rv_pkg::word_t encR(input logic [6:0] f7, input logic [2:0] f3,
                                         input rv_pkg::regIdx_t rd, input rv_pkg::regIdx_t rs1,
                                         input rv_pkg::regIdx_t rs2);
    return {f7, rs2, rs1, f3, rd, `OP_OP};
  endfunction

  function automatic rv_pkg::word_t encI(input logic [11:0] imm, input logic [2:0] f3,
                                         input rv_pkg::regIdx_t rd, input rv_pkg::regIdx_t rs1,
                                         input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_pkg::word_t encB(input logic [12:0] imm, input logic [2:0] f3,
                                         input rv_pkg::regIdx_t rs1, input rv_pkg::regIdx_t rs2);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
  endfunction

  function automatic rv_pkg::word_t encU(input logic [19:0] imm, input rv_pkg::regIdx_t rd);
    return {imm, rd, `OP_LUI};
  endfunction

  function automatic rv_pkg::word_t encJ(input logic [20:0] imm, input rv_pkg::regIdx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
  endfunction

  function automatic logic [6:0] noOpOpcode(input logic [2:0] sel);
    case (sel)
      3'd0: return `OP_LOAD;
      3'd1: return `OP_STORE;
      3'd2: return `OP_FENCE;
      3'd3: return `OP_SYSTEM;
      // auipc is left undecoded
      3'd4: return 7'b0010111;
      3'd5: return 7'b1111111;
      3'd6: return 7'b0000000;
      default: return 7'b1011011;
    endcase
  endfunction

  // f 0..7 is funct3, 8 is sra or srai, 9 is sub
  function automatic rv_pkg::word_t aluInstr(input logic isReg, input int f,
                                             input rv_pkg::word_t r);
    logic [2:0]      f3;
    logic            alt;
    rv_pkg::regIdx_t rd;
    rv_pkg::regIdx_t rs1;
    f3 = (f == 8) ? 3'b101 : (f == 9) ? 3'b000 : f[2:0];
    alt = (f >= 8);
    rd = {2'b0, r[2:0]};
    rs1 = {2'b0, r[5:3]};
    if (isReg) return encR({1'b0, alt, 5'd0}, f3, rd, rs1, {2'b0, r[8:6]});
    if (f3 == 3'b001 || f3 == 3'b101) begin
      return encI({1'b0, alt, 5'd0, r[20:16]}, f3, rd, rs1, `OP_OPIMM);
    end
    return encI(r[31:20], f3, rd, rs1, `OP_OPIMM);
  endfunction

  // registers limited to x0..x7 so results feed the next instructions
  function automatic rv_pkg::word_t randomInstr();
    rv_pkg::word_t   r;
    rv_pkg::word_t   r2;
    rv_pkg::regIdx_t rd;
    logic [2:0]      f3;
    r = rnd();
    r2 = rnd();
    rd = {2'b0, r[2:0]};
    f3 = r[11:9];
    case (r[31:29])
      3'd0: return encU(r2[19:0], rd);
      3'd1, 3'd2: return aluInstr(1'b0, int'(r[15:12]) % 9, r2);
      3'd3: return aluInstr(1'b1, int'(r[15:12]) % 10, r2);
      3'd4: return encB({r2[12:1], 1'b0}, {f3[2], f3[2] & f3[1], f3[0]},
                        {2'b0, r[5:3]}, {2'b0, r[8:6]});
      3'd5: return encJ({r2[20:1], 1'b0}, rd);
      3'd6: return encI(r2[11:0], 3'b000, rd, {2'b0, r[5:3]}, `OP_JALR);
      default: return {r2[31:7], noOpOpcode(r[14:12])};
    endcase
  endfunction

  task automatic issueInstr(input rv_pkg::word_t w);
    stepResult_t s;
    @(posedge clk);
    instr <= w;
    instrValid <= 1'b1;
    s = modelStep(model, w);
    model = s.next;
    expQ.push_back(s.exp);
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge clk);
      instrValid <= 1'b0;
    end
  endtask

  task automatic endTest(input string name);
    @(posedge clk);
    instrValid <= 1'b0;
    while (expQ.size() != 0) @(posedge clk);
    testNum++;
    if (errorCount == testErrors) begin
      $display("test %0d %s: ok", testNum, name);
    end else begin
      $display("test %0d %s: %0d mismatches", testNum, name, errorCount - testErrors);
      failedTests++;
    end
    testErrors = errorCount;
  endtask

  task automatic compareValue(input string name, input rv_pkg::word_t expVal,
                              input rv_pkg::word_t actVal);
    assert (actVal === expVal) else begin
      $display("** Error at %0t: %s expected 0x%08h, actual 0x%08h", $time, name, expVal, actVal);
      errorCount++;
    end
  endtask

  // outputs are sampled mid-cycle on the falling edge
  always @(negedge clk) begin : checkOutputs
    expect_t e;
    if (running) begin
      e = '0;
      e.pc = lastPc;
      if (armed) begin
        e = expQ.pop_front();
      end
      lastPc = e.pc;
      checkCount++;
      compareValue("wbValid", {31'd0, e.wbValid}, {31'd0, wbValid});
      if (e.wbValid) begin
        compareValue("wbRd", {27'd0, e.rd}, {27'd0, wbRd});
        compareValue("wbData", e.data, wbData);
      end
      compareValue("pc", e.pc, pc);
      armed = instrValid;
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin : runTests
    rv_pkg::word_t   r;
    logic [2:0]      f3;
    rv_pkg::regIdx_t rs1;
    rv_pkg::regIdx_t rs2;
    seed = 32'h83d9a711;
    arstN = 1'b0;
    instr = '0;
    instrValid = 1'b0;
    errorCount = 0;
    checkCount = 0;
    testNum = 0;
    testErrors = 0;
    failedTests = 0;
    running = 1'b0;
    armed = 1'b0;
    lastPc = `RESET_PC;
    model = '0;
    model.pc = `RESET_PC;
    repeat (8) @(posedge clk);
    arstN <= 1'b1;
    running = 1'b1;
    idleCycles(6);
    endTest("reset and idle");

    for (int i = 1; i < 8; i++) begin
      r = rnd();
      issueInstr(encU(r[31:12], i[4:0]));
      issueInstr(encI(r[11:0], 3'b000, i[4:0], i[4:0], `OP_OPIMM));
    end
    for (int k = 0; k < ALU_ROUNDS; k++) begin
      for (int f = 0; f < 9; f++) issueInstr(aluInstr(1'b0, f, rnd()));
      for (int f = 0; f < 10; f++) issueInstr(aluInstr(1'b1, f, rnd()));
    end
    // writes to x0 are dropped, then x0 is read back
    issueInstr(encI(12'h123, 3'b000, 5'd0, 5'd1, `OP_OPIMM));
    issueInstr(encR(7'd0, 3'b000, 5'd0, 5'd1, 5'd2));
    issueInstr(encR(7'd0, 3'b000, 5'd5, 5'd0, 5'd0));
    endTest("lui and alu");

    // x1 negative, x2 positive, x3 compared with itself
    r = rnd();
    issueInstr(encU({1'b1, r[18:0]}, 5'd1));
    issueInstr(encU({1'b0, r[30:12]}, 5'd2));
    issueInstr(encU(r[19:0], 5'd3));
    for (int c = 0; c < 6; c++) begin
      f3 = (c < 2) ? c[2:0] : c[2:0] + 3'd2;
      for (int p = 0; p < 3; p++) begin
        rs1 = (p == 0) ? 5'd1 : (p == 1) ? 5'd2 : 5'd3;
        rs2 = (p == 0) ? 5'd2 : (p == 1) ? 5'd1 : 5'd3;
        for (int s = 0; s < 2; s++) begin
          r = rnd();
          issueInstr(encB({s[0], r[10:0], 1'b0}, f3, rs1, rs2));
        end
      end
    end
    endTest("branches");

    for (int k = 0; k < 4; k++) begin
      r = rnd();
      issueInstr(encJ({r[31:12], 1'b0}, {2'b0, r[2:0]}));
      r = rnd();
      issueInstr(encI(r[31:20], 3'b000, {2'b0, r[2:0]}, {2'b0, r[5:3]}, `OP_JALR));
    end
    endTest("jal and jalr");

    for (int k = 0; k < 12; k++) begin
      r = rnd();
      issueInstr({r[31:7], noOpOpcode(k[2:0])});
    end
    endTest("no-op opcodes");

    for (int k = 0; k < STREAM_LEN; k++) begin
      issueInstr(randomInstr());
      r = rnd();
      if (r[1:0] == 2'b00) idleCycles(int'(r[3:2]) + 1);
    end
    endTest("random stream");

    $display("tests %0d, failed %0d, cycles checked %0d, errors %0d",
             testNum, failedTests, checkCount, errorCount);
    if (errorCount == 0 && failedTests == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/rv_core.sv ====
`default_nettype none

module rv_core (
  input  wire                 clk,
  input  wire                 arstN,
  input  wire rv_pkg::word_t  instr,
  input  wire                 instrValid,
  output rv_pkg::word_t       pc,
  output logic                wbValid,
  output rv_pkg::regIdx_t     wbRd,
  output rv_pkg::word_t       wbData
);

  rv_pkg::decoded_t  dec;
  rv_pkg::exResult_t res;
  rv_pkg::word_t     rdata1;
  rv_pkg::word_t     rdata2;
  logic              regWriteEn;
  rv_pkg::regIdx_t   regRd;
  rv_pkg::word_t     regWdata;

  decode uDecode (
    .instr (instr),
    .dec   (dec)
  );

  // operands read straight from the decoded indices
  reg_file uRegFile (
    .clk     (clk),
    .arstN   (arstN),
    .rs1     (dec.rs1),
    .rs2     (dec.rs2),
    .rdata1  (rdata1),
    .rdata2  (rdata2),
    .writeEn (regWriteEn),
    .rd      (regRd),
    .wdata   (regWdata)
  );

  execute uExecute (
    .dec    (dec),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .pc     (pc),
    .res    (res)
  );

  result uResult (
    .clk        (clk),
    .arstN      (arstN),
    .instrValid (instrValid),
    .res        (res),
    .pc         (pc),
    .regWriteEn (regWriteEn),
    .regRd      (regRd),
    .regWdata   (regWdata),
    .wbValid    (wbValid),
    .wbRd       (wbRd),
    .wbData     (wbData)
  );

endmodule

`default_nettype wire

// ==== src/result.sv ====
`default_nettype none

`include "rv_defines.svh"

module result (
  input  wire                    clk,
  input  wire                    arstN,
  input  wire                    instrValid,
  input  wire rv_pkg::exResult_t res,
  output rv_pkg::word_t          pc,
  output logic                   regWriteEn,
  output rv_pkg::regIdx_t        regRd,
  output rv_pkg::word_t          regWdata,
  output logic                   wbValid,
  output rv_pkg::regIdx_t        wbRd,
  output rv_pkg::word_t          wbData
);

  // register file sees the write at the same edge as the record
  assign regWriteEn = instrValid && res.writeEn;
  assign regRd      = res.rd;
  assign regWdata   = res.data;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pc <= `RESET_PC;
    end else if (instrValid) begin
      pc <= res.nextPc;
    end
  end

  // record only pulses for instructions that write a register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbValid <= 1'b0;
    end else begin
      wbValid <= regWriteEn;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wbRd   <= '0;
      wbData <= '0;
    end else if (instrValid) begin
      wbRd   <= res.rd;
      wbData <= res.data;
    end
  end

endmodule

`default_nettype wire

// ==== src/execute.sv ====
`default_nettype none

`include "rv_defines.svh"

module execute (
  input  wire rv_pkg::decoded_t dec,
  input  wire rv_pkg::word_t    rdata1,
  input  wire rv_pkg::word_t    rdata2,
  input  wire rv_pkg::word_t    pc,
  output rv_pkg::exResult_t     res
);

  rv_pkg::aluOp_t aluOp;
  rv_pkg::word_t  opB;
  rv_pkg::word_t  aluOut;
  rv_pkg::word_t  pcPlus4;
  rv_pkg::word_t  pcPlusImm;
  rv_pkg::word_t  jalrTarget;
  logic           isOpImm;
  logic           isReg;
  logic           altBit;
  logic           taken;
  logic [4:0]     shamt;

  assign isOpImm = (dec.instrType == rv_pkg::TYPE_I) && (dec.opcode == `OP_OPIMM);
  assign isReg   = (dec.instrType == rv_pkg::TYPE_R);

  // sub/sra select, imm bit 10 is instr bit 30 for shift-immediates
  assign altBit = isReg ? dec.funct7[5] : dec.imm[10];

  assign opB   = isReg ? rdata2 : dec.imm;
  assign shamt = opB[4:0];

  always_comb begin
    aluOp = rv_pkg::ALU_ADD;
    if (dec.instrType == rv_pkg::TYPE_U) begin
      aluOp = rv_pkg::ALU_PASSB;
    end else if (isReg || isOpImm) begin
      case (dec.funct3)
        3'b000:  aluOp = (isReg && altBit) ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
        3'b001:  aluOp = rv_pkg::ALU_SLL;
        3'b010:  aluOp = rv_pkg::ALU_SLT;
        3'b011:  aluOp = rv_pkg::ALU_SLTU;
        3'b100:  aluOp = rv_pkg::ALU_XOR;
        3'b101:  aluOp = altBit ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
        3'b110:  aluOp = rv_pkg::ALU_OR;
        default: aluOp = rv_pkg::ALU_AND;
      endcase
    end
  end

  always_comb begin
    case (aluOp)
      rv_pkg::ALU_SUB:   aluOut = rdata1 - opB;
      rv_pkg::ALU_SLL:   aluOut = rdata1 << shamt;
      rv_pkg::ALU_SLT:   aluOut = {31'd0, $signed(rdata1) < $signed(opB)};
      rv_pkg::ALU_SLTU:  aluOut = {31'd0, rdata1 < opB};
      rv_pkg::ALU_XOR:   aluOut = rdata1 ^ opB;
      rv_pkg::ALU_SRL:   aluOut = rdata1 >> shamt;
      rv_pkg::ALU_SRA:   aluOut = $signed(rdata1) >>> shamt;
      rv_pkg::ALU_OR:    aluOut = rdata1 | opB;
      rv_pkg::ALU_AND:   aluOut = rdata1 & opB;
      rv_pkg::ALU_PASSB: aluOut = opB;
      default:           aluOut = rdata1 + opB;
    endcase
  end

  // branch condition, reserved funct3 never taken
  always_comb begin
    case (dec.funct3)
      3'b000:  taken = (rdata1 == rdata2);
      3'b001:  taken = (rdata1 != rdata2);
      3'b100:  taken = ($signed(rdata1) < $signed(rdata2));
      3'b101:  taken = ($signed(rdata1) >= $signed(rdata2));
      3'b110:  taken = (rdata1 < rdata2);
      3'b111:  taken = (rdata1 >= rdata2);
      default: taken = 1'b0;
    endcase
  end

  assign pcPlus4    = pc + 32'd4;
  assign pcPlusImm  = pc + dec.imm;
  assign jalrTarget = (rdata1 + dec.imm) & ~32'd1;

  always_comb begin
    res.writeEn = 1'b0;
    res.rd      = dec.rd;
    res.data    = aluOut;
    res.nextPc  = pcPlus4;
    case (dec.instrType)
      rv_pkg::TYPE_U, rv_pkg::TYPE_R: begin
        res.writeEn = 1'b1;
      end
      rv_pkg::TYPE_J: begin
        res.writeEn = 1'b1;
        res.data    = pcPlus4;
        res.nextPc  = pcPlusImm;
      end
      rv_pkg::TYPE_B: begin
        res.nextPc = taken ? pcPlusImm : pcPlus4;
      end
      rv_pkg::TYPE_I: begin
        if (dec.opcode == `OP_JALR) begin
          res.writeEn = 1'b1;
          res.data    = pcPlus4;
          res.nextPc  = jalrTarget;
        end else begin
          // loads, fence and system retire without a write
          res.writeEn = isOpImm;
        end
      end
      default: begin
        res.writeEn = 1'b0;
      end
    endcase
    if (dec.rd == 5'd0) begin
      res.writeEn = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`default_nettype none

module reg_file (
  input  wire                 clk,
  input  wire                 arstN,
  input  wire rv_pkg::regIdx_t rs1,
  input  wire rv_pkg::regIdx_t rs2,
  output rv_pkg::word_t        rdata1,
  output rv_pkg::word_t        rdata2,
  input  wire                 writeEn,
  input  wire rv_pkg::regIdx_t rd,
  input  wire rv_pkg::word_t   wdata
);

  rv_pkg::word_t regs [32];

  // entry 0 is never written
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  // x0 always reads zero
  assign rdata1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign rdata2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

// ==== src/decode.sv ====
`default_nettype none

`include "rv_defines.svh"

module decode (
  input  wire rv_pkg::word_t instr,
  output rv_pkg::decoded_t   dec
);

  always_comb begin
    // unused fields stay zero
    dec = '0;
    dec.opcode = instr[6:0];

    case (instr[6:0])
      `OP_LUI: begin
        dec.rd = instr[11:7];
        dec.imm = {instr[31:12], 12'b0};
        dec.instrType = rv_pkg::TYPE_U;
      end

      `OP_JAL: begin
        dec.rd = instr[11:7];
        dec.imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        dec.instrType = rv_pkg::TYPE_J;
      end

      `OP_BRANCH: begin
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.funct3 = instr[14:12];
        dec.imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        dec.instrType = rv_pkg::TYPE_B;
      end

      // jalr, loads, op-imm, fence and system share the I format
      `OP_JALR, `OP_LOAD, `OP_OPIMM, `OP_FENCE, `OP_SYSTEM: begin
        dec.rd = instr[11:7];
        dec.rs1 = instr[19:15];
        dec.funct3 = instr[14:12];
        dec.imm = {{21{instr[31]}}, instr[30:20]};
        dec.instrType = rv_pkg::TYPE_I;
      end

      `OP_STORE: begin
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.funct3 = instr[14:12];
        dec.imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
        dec.instrType = rv_pkg::TYPE_S;
      end

      `OP_OP: begin
        dec.rd = instr[11:7];
        dec.rs1 = instr[19:15];
        dec.rs2 = instr[24:20];
        dec.funct3 = instr[14:12];
        dec.funct7 = instr[31:25];
        dec.instrType = rv_pkg::TYPE_R;
      end

      default: begin
        // auipc and anything unknown
        dec.instrType = rv_pkg::TYPE_NONE;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regIdx_t;

  // instruction format, encodings follow the decoder
  typedef enum logic [2:0] {
    TYPE_NONE = 3'd0,
    TYPE_U    = 3'd1,
    TYPE_J    = 3'd2,
    TYPE_B    = 3'd3,
    TYPE_I    = 3'd4,
    TYPE_S    = 3'd5,
    TYPE_R    = 3'd6
  } instrType_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASSB
  } aluOp_t;

  typedef struct packed {
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    regIdx_t    rd;
    regIdx_t    rs1;
    regIdx_t    rs2;
    word_t      imm;
    instrType_t instrType;
  } decoded_t;

  // execute outcome, consumed by the result stage
  typedef struct packed {
    logic    writeEn;
    regIdx_t rd;
    word_t   data;
    word_t   nextPc;
  } exResult_t;

endpackage

`default_nettype wire

// ==== src/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// program counter after reset
`define RESET_PC 32'h0000_1000

// RV32I major opcodes
`define OP_LUI    7'b0110111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_OPIMM  7'b0010011
`define OP_OP     7'b0110011
`define OP_FENCE  7'b0001111
`define OP_SYSTEM 7'b1110011

`endif
